/* Makefile */
VERILATOR  ?= verilator
TOP        := pe_tb
FILELIST   := pe.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/10ps -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall --timescale 1ns/10ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* design/complex_alu.sv */
`timescale 1ns/10ps
`include "pe_settings.svh"

module complex_alu (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    alu_v,
    input  pe_data_pkg::alu_op_e    alu_op,
    input  pe_data_pkg::cpx_t       din_1,
    input  pe_data_pkg::cpx_t       din_2,
    output logic                    dout_v,
    output pe_data_pkg::cpx_t       dout
);

    localparam int W = `CPX_WIDTH;

    // Stage one registers
    logic                   v1;
    pe_data_pkg::alu_op_e   op1;
    logic signed [2*W-1:0]  p_rr;   // ar*br
    logic signed [2*W-1:0]  p_ii;   // ai*bi
    logic signed [2*W-1:0]  p_ri;   // ar*bi
    logic signed [2*W-1:0]  p_ir;   // ai*br
    logic signed [W-1:0]    lin_re; // Sum, difference or pass
    logic signed [W-1:0]    lin_im;

    // Stage two combine
    logic signed [2*W-1:0]  full_re;
    logic signed [2*W-1:0]  full_im;
    pe_data_pkg::cpx_t      res_next;

    //////////////////////////////////////////////////
    // Stage one
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        op1  <= alu_op;
        p_rr <= din_1.re * din_2.re;
        p_ii <= din_1.im * din_2.im;
        p_ri <= din_1.re * din_2.im;
        p_ir <= din_1.im * din_2.re;
        case (alu_op)
            pe_data_pkg::ALU_ADD: begin
                lin_re <= din_1.re + din_2.re;      // Wraps at W bits
                lin_im <= din_1.im + din_2.im;
            end
            pe_data_pkg::ALU_SUB: begin
                lin_re <= din_1.re - din_2.re;
                lin_im <= din_1.im - din_2.im;
            end
            default: begin
                lin_re <= din_1.re;
                lin_im <= din_1.im;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Stage two
    //////////////////////////////////////////////////
    always_comb begin
        full_re = {{W{lin_re[W-1]}}, lin_re};
        full_im = {{W{lin_im[W-1]}}, lin_im};
        case (op1)
            pe_data_pkg::ALU_MUL: begin
                full_re = p_rr - p_ii;
                full_im = p_ri + p_ir;
            end
            pe_data_pkg::ALU_CMUL: begin
                // Conjugate of din_2 flips the sign of bi
                full_re = p_rr + p_ii;
                full_im = p_ir - p_ri;
            end
            default: ;                              // Linear result as is
        endcase
        res_next.re = full_re[W-1:0];               // Keep low bits only
        res_next.im = full_im[W-1:0];
    end

    always_ff @(posedge clk) begin
        dout <= res_next;
    end

    // Valid pipe, one bit per stage
    always_ff @(posedge clk) begin
        if (reset) begin
            v1     <= 1'b0;
            dout_v <= 1'b0;
        end else begin
            v1     <= alu_v;
            dout_v <= v1;
        end
    end

endmodule

/* design/data_mem.sv */
`timescale 1ns/10ps
`include "pe_settings.svh"

module data_mem (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`DMEM_AW-1:0]     rd_addr0,
    input  logic [`DMEM_AW-1:0]     rd_addr1,
    input  logic                    wr_en,
    input  logic [`DMEM_AW-1:0]     wr_addr,
    input  pe_data_pkg::cpx_t       wr_data,
    output pe_data_pkg::cpx_t       rd_data0,
    output pe_data_pkg::cpx_t       rd_data1
);

    pe_data_pkg::cpx_t mem [`DMEM_DEPTH];   // Sample store

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////
    // Two registered read ports
    //////////////////////////////////////////////////
    // Same-cycle write to the read address gives the old word
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data0 <= '0;
            rd_data1 <= '0;
        end else begin
            rd_data0 <= mem[rd_addr0];              // Operand A
            rd_data1 <= mem[rd_addr1];              // Operand B
        end
    end

endmodule

/* design/inst_mem.sv */
`timescale 1ns/10ps
`include "pe_settings.svh"

module inst_mem (
    input  logic                clk,
    input  logic                reset,
    input  logic                inst_in_v,
    input  pe_isa_pkg::inst_t   inst_in,
    output logic                issue_v,
    output pe_isa_pkg::inst_t   issue_inst
);

    localparam int PTR_W = `IMEM_AW + 1;    // Room for a full count

    pe_isa_pkg::inst_t      mem [`IMEM_DEPTH];
    logic [PTR_W-1:0]       load_ptr;       // Next slot, also the loaded count
    logic [PTR_W-1:0]       pc;
    logic [`IMEM_AW-1:0]    wr_addr;
    logic                   loading;        // Inside a burst
    logic                   running;

    // First word of a burst always lands in slot 0
    assign wr_addr = loading ? load_ptr[`IMEM_AW-1:0] : '0;

    always_ff @(posedge clk) begin
        if (inst_in_v) begin
            mem[wr_addr] <= inst_in;
        end
    end

    //////////////////////////////////////////////////
    // Load pointer, PC and run control
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            load_ptr <= '0;
            pc       <= '0;
            loading  <= 1'b0;
            running  <= 1'b0;
        end else if (inst_in_v) begin
            loading  <= 1'b1;
            running  <= 1'b0;                       // Abort any run
            load_ptr <= loading ? load_ptr + 1'b1 : PTR_W'(1);
            pc       <= '0;
        end else if (loading) begin
            // Burst just ended, start from slot 0
            loading <= 1'b0;
            running <= 1'b1;
            pc      <= '0;
        end else if (running) begin
            if (pc == load_ptr - 1'b1) begin
                running <= 1'b0;                    // Last slot issued
            end
            pc <= pc + 1'b1;
        end
    end

    assign issue_v    = running;
    assign issue_inst = mem[pc[`IMEM_AW-1:0]];     // Async read of current slot

endmodule

/* design/pe.sv */
`timescale 1ns/10ps
`include "pe_settings.svh"

module pe (
    input  logic                clk,
    input  logic                reset,
    input  logic                din_v,
    input  pe_data_pkg::cpx_t   din_pe,
    input  logic                inst_in_v,
    input  pe_isa_pkg::inst_t   inst_in,
    output logic                dout_v,
    output pe_data_pkg::cpx_t   dout_pe,
    output logic                inst_out_v,
    output pe_isa_pkg::inst_t   inst_out
);

    logic                   issue_v;
    pe_isa_pkg::inst_t      issue_inst;     // Slot at the PC
    logic [`DMEM_AW-1:0]    rd_addr0;
    logic [`DMEM_AW-1:0]    rd_addr1;
    logic                   wr_en;
    logic [`DMEM_AW-1:0]    wr_addr;
    pe_data_pkg::cpx_t      wr_data;
    pe_data_pkg::cpx_t      rd_data0;
    pe_data_pkg::cpx_t      rd_data1;
    logic                   alu_v;
    pe_data_pkg::alu_op_e   alu_op;

    //////////////////////////////////////////////////
    // Forward to the next PE in the array
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            inst_out_v <= 1'b0;
        end else begin
            inst_out_v <= inst_in_v;
        end
    end

    always_ff @(posedge clk) begin
        inst_out <= inst_in;                        // Qualified by inst_out_v
    end

    inst_mem u_imem (
        .clk        (clk),
        .reset      (reset),
        .inst_in_v  (inst_in_v),
        .inst_in    (inst_in),
        .issue_v    (issue_v),
        .issue_inst (issue_inst)
    );

    pe_decoder u_dec (
        .clk        (clk),
        .reset      (reset),
        .issue_v    (issue_v),
        .issue_inst (issue_inst),
        .din_v      (din_v),
        .din_pe     (din_pe),
        .res_v      (dout_v),                       // Write-back path
        .res        (dout_pe),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .alu_v      (alu_v),
        .alu_op     (alu_op)
    );

    data_mem u_dmem (
        .clk        (clk),
        .reset      (reset),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1)
    );

    complex_alu u_alu (
        .clk        (clk),
        .reset      (reset),
        .alu_v      (alu_v),
        .alu_op     (alu_op),
        .din_1      (rd_data0),
        .din_2      (rd_data1),
        .dout_v     (dout_v),
        .dout       (dout_pe)
    );

endmodule

/* design/pe_data_pkg.sv */
`include "pe_settings.svh"

package pe_data_pkg;

    // Complex sample, real half on top
    typedef struct packed {
        logic signed [`CPX_WIDTH-1:0] re;
        logic signed [`CPX_WIDTH-1:0] im;
    } cpx_t;

    //////////////////////////////////////////////////
    // Datapath operations
    //////////////////////////////////////////////////
    // Own encoding, decoupled from the opcodes
    typedef enum logic [2:0] {
        ALU_PASS,               // din_1 straight through
        ALU_ADD,                // din_1 + din_2
        ALU_SUB,                // din_1 - din_2
        ALU_MUL,                // din_1 * din_2
        ALU_CMUL                // din_1 * conj(din_2)
    } alu_op_e;

endpackage

/* design/pe_decoder.sv */
`timescale 1ns/10ps
`include "pe_settings.svh"

module pe_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    issue_v,
    input  pe_isa_pkg::inst_t       issue_inst,
    input  logic                    din_v,
    input  pe_data_pkg::cpx_t       din_pe,
    input  logic                    res_v,
    input  pe_data_pkg::cpx_t       res,
    output logic [`DMEM_AW-1:0]     rd_addr0,
    output logic [`DMEM_AW-1:0]     rd_addr1,
    output logic                    wr_en,
    output logic [`DMEM_AW-1:0]     wr_addr,
    output pe_data_pkg::cpx_t       wr_data,
    output logic                    alu_v,
    output pe_data_pkg::alu_op_e    alu_op
);

    localparam int DEPTH = `PE_LATENCY;     // Decode reg plus ALU stages

    pe_data_pkg::alu_op_e   op_next;
    logic                   op_valid;       // Legal non-NOP opcode
    logic [`DMEM_AW-1:0]    dst_q [DEPTH];  // Index 0 is youngest
    logic [DEPTH-1:0]       wb_q;
    logic [`DMEM_AW-1:0]    load_ptr;
    logic [`DMEM_AW-1:0]    load_addr;
    logic                   din_v_q;

    // Operands leave in the issue cycle
    assign rd_addr0 = issue_inst.src0;
    assign rd_addr1 = issue_inst.src1;

    //////////////////////////////////////////////////
    // Opcode to ALU op
    //////////////////////////////////////////////////
    always_comb begin
        op_valid = 1'b1;
        op_next  = pe_data_pkg::ALU_PASS;
        case (issue_inst.opcode)
            pe_isa_pkg::OP_MOV:  op_next = pe_data_pkg::ALU_PASS;
            pe_isa_pkg::OP_ADD:  op_next = pe_data_pkg::ALU_ADD;
            pe_isa_pkg::OP_SUB:  op_next = pe_data_pkg::ALU_SUB;
            pe_isa_pkg::OP_MUL:  op_next = pe_data_pkg::ALU_MUL;
            pe_isa_pkg::OP_CMUL: op_next = pe_data_pkg::ALU_CMUL;
            default:             op_valid = 1'b0;   // NOP and spare codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_v   <= 1'b0;
            wb_q    <= '0;
            din_v_q <= 1'b0;
            load_ptr <= '0;
        end else begin
            alu_v   <= issue_v & op_valid;
            wb_q    <= {wb_q[DEPTH-2:0], issue_v & op_valid & issue_inst.wb};
            din_v_q <= din_v;
            if (din_v) begin
                load_ptr <= load_addr + 1'b1;
            end
        end
    end

    // Op and destination ride along, valid bits gate them
    always_ff @(posedge clk) begin
        alu_op   <= op_next;
        dst_q[0] <= issue_inst.dst;
        for (int i = 1; i < DEPTH; i++) begin
            dst_q[i] <= dst_q[i-1];
        end
    end

    // Each data burst restarts at address 0
    assign load_addr = din_v_q ? load_ptr : '0;

    //////////////////////////////////////////////////
    // Data memory write source
    //////////////////////////////////////////////////
    always_comb begin
        if (din_v) begin                            // External load wins
            wr_en   = 1'b1;
            wr_addr = load_addr;
            wr_data = din_pe;
        end else begin
            wr_en   = res_v & wb_q[DEPTH-1];        // Aligned with dout_v
            wr_addr = dst_q[DEPTH-1];
            wr_data = res;
        end
    end

endmodule

/* design/pe_isa_pkg.sv */
`include "pe_settings.svh"

package pe_isa_pkg;

    // Instruction set opcodes, 6 and 7 unused
    typedef enum logic [2:0] {
        OP_NOP  = 3'd0,
        OP_MOV  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4,
        OP_CMUL = 3'd5
    } opcode_e;

    // Bits left over after the used fields
    localparam int RSVD_WIDTH = `INST_WIDTH - 3 - 1 - 3 * `DMEM_AW;

    //////////////////////////////////////////////////
    // Instruction word, MSB first
    //////////////////////////////////////////////////
    typedef struct packed {
        opcode_e                opcode;     // Operation
        logic                   wb;         // Write result back
        logic [`DMEM_AW-1:0]    dst;        // Write-back address
        logic [`DMEM_AW-1:0]    src0;       // First operand
        logic [`DMEM_AW-1:0]    src1;       // Second operand
        logic [RSVD_WIDTH-1:0]  rsvd;       // Zero
    } inst_t;

endpackage

/* include/pe_settings.svh */
`ifndef PE_SETTINGS_SVH
`define PE_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

`define CPX_WIDTH   16          // One real or imaginary component
`define INST_WIDTH  32          // Full instruction word

//////////////////////////////////////////////////
// Memory sizes
//////////////////////////////////////////////////

`define IMEM_DEPTH  16          // Program slots
`define IMEM_AW     4
`define DMEM_DEPTH  16          // Complex sample slots
`define DMEM_AW     4

// Issue to dout_v, in cycles
`define PE_LATENCY  3

`endif

/* pe.f */
+incdir+include
design/pe_data_pkg.sv
design/pe_isa_pkg.sv
design/inst_mem.sv
design/pe_decoder.sv
design/data_mem.sv
design/complex_alu.sv
design/pe.sv
tb/pe_properties.sv
tb/pe_tb.sv

/* tb/pe_properties.sv */
`timescale 1ns/10ps

module pe_properties (
    input logic                 clk,
    input logic                 reset,
    input logic                 inst_in_v,
    input pe_isa_pkg::inst_t    inst_in,
    input logic                 inst_out_v,
    input pe_isa_pkg::inst_t    inst_out,
    input logic                 dout_v
);

    //////////////////////////////////////////////////
    // Instruction forwarding to the next PE
    //////////////////////////////////////////////////
    a_fwd_strobe: assert property (@(posedge clk) disable iff (reset)
        inst_out_v == $past(inst_in_v))
    else $error("inst_out_v is not inst_in_v delayed by one cycle");

    // Word travels with its strobe
    a_fwd_word: assert property (@(posedge clk) disable iff (reset)
        inst_out_v |-> inst_out == $past(inst_in))
    else $error("inst_out differs from the previous inst_in");

    // Nothing in flight right out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !dout_v)
    else $error("dout_v high in the first cycle after reset");

endmodule

bind pe pe_properties u_props (
    .clk        (clk),
    .reset      (reset),
    .inst_in_v  (inst_in_v),
    .inst_in    (inst_in),
    .inst_out_v (inst_out_v),
    .inst_out   (inst_out),
    .dout_v     (dout_v)
);

/* tb/pe_tb.sv */
`timescale 1ns/10ps
`include "pe_settings.svh"

module pe_tb;

    localparam int CLK_PERIOD  = 10;
    localparam int DRIVE_DELAY = 1;                 // After the rising edge
    localparam int AW          = `DMEM_AW;
    localparam int WAIT_LIMIT  = `IMEM_DEPTH + `PE_LATENCY + 8;
    // Worst case per run is a data burst, a program burst and the drain
    localparam int RUN_CYCLES  = `DMEM_DEPTH + 2 * `IMEM_DEPTH + `PE_LATENCY + 24;
    localparam int NUM_RUNS    = 7;
    localparam int WATCHDOG_NS = (NUM_RUNS * RUN_CYCLES + 40) * CLK_PERIOD;

    logic                   clk;
    logic                   reset;
    logic                   din_v;
    pe_data_pkg::cpx_t      din_pe;
    logic                   inst_in_v;
    pe_isa_pkg::inst_t      inst_in;
    logic                   dout_v;
    pe_data_pkg::cpx_t      dout_pe;
    logic                   inst_out_v;
    pe_isa_pkg::inst_t      inst_out;

    logic [31:0]            lfsr_state;
    pe_data_pkg::cpx_t      model_mem [`DMEM_DEPTH];    // Mirror of data_mem
    pe_data_pkg::cpx_t      data_q [$];                 // Next data burst
    pe_isa_pkg::inst_t      prog_q [$];                 // Next program burst
    pe_data_pkg::cpx_t      exp_q [$];
    pe_data_pkg::cpx_t      result_q [$];               // Seen on dout_pe
    pe_isa_pkg::inst_t      fwd_q [$];                  // Seen on inst_out

    pe dut_i (
        .clk        (clk),
        .reset      (reset),
        .din_v      (din_v),
        .din_pe     (din_pe),
        .inst_in_v  (inst_in_v),
        .inst_in    (inst_in),
        .dout_v     (dout_v),
        .dout_pe    (dout_pe),
        .inst_out_v (inst_out_v),
        .inst_out   (inst_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset && dout_v) begin
            result_q.push_back(dout_pe);
        end
        if (!reset && inst_out_v) begin
            fwd_q.push_back(inst_out);
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Galois form
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic pe_data_pkg::cpx_t random_sample();
        return pe_data_pkg::cpx_t'(random_bits(2 * `CPX_WIDTH));
    endfunction

    function automatic logic [AW-1:0] random_addr(input int n);
        logic [31:0] v;
        v = random_bits(n);                         // n bits, upper ones zero
        return v[AW-1:0];
    endfunction

    function automatic pe_isa_pkg::inst_t make_inst(
        input pe_isa_pkg::opcode_e  op,
        input logic                 wb,
        input logic [AW-1:0]        dst,
        input logic [AW-1:0]        src0,
        input logic [AW-1:0]        src1
    );
        pe_isa_pkg::inst_t w;
        w        = '0;                              // Reserved bits stay zero
        w.opcode = op;
        w.wb     = wb;
        w.dst    = dst;
        w.src0   = src0;
        w.src1   = src1;
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    // Full-precision integer math, then keep the low component bits
    function automatic pe_data_pkg::cpx_t model_op(
        input pe_isa_pkg::opcode_e  op,
        input pe_data_pkg::cpx_t    a,
        input pe_data_pkg::cpx_t    b
    );
        int                 ar;
        int                 ai;
        int                 br;
        int                 bi;
        int                 re;
        int                 im;
        pe_data_pkg::cpx_t  r;
        ar = int'(a.re);
        ai = int'(a.im);
        br = int'(b.re);
        bi = int'(b.im);
        re = 0;
        im = 0;
        case (op)
            pe_isa_pkg::OP_MOV: begin
                re = ar;
                im = ai;
            end
            pe_isa_pkg::OP_ADD: begin
                re = ar + br;
                im = ai + bi;
            end
            pe_isa_pkg::OP_SUB: begin
                re = ar - br;
                im = ai - bi;
            end
            pe_isa_pkg::OP_MUL: begin
                re = ar * br - ai * bi;
                im = ar * bi + ai * br;
            end
            pe_isa_pkg::OP_CMUL: begin           // a * (br - j bi)
                re = ar * br + ai * bi;
                im = ai * br - ar * bi;
            end
            default: ;
        endcase
        r.re = re[`CPX_WIDTH-1:0];
        r.im = im[`CPX_WIDTH-1:0];
        return r;
    endfunction

    // Programs keep producers four slots ahead, so in-order is exact
    function automatic void predict_program();
        pe_data_pkg::cpx_t r;
        foreach (prog_q[k]) begin
            if (prog_q[k].opcode != pe_isa_pkg::OP_NOP) begin
                r = model_op(prog_q[k].opcode, model_mem[prog_q[k].src0],
                             model_mem[prog_q[k].src1]);
                exp_q.push_back(r);
                if (prog_q[k].wb) begin
                    model_mem[prog_q[k].dst] = r;
                end
            end
        end
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: %s expected %h actual %h", test, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Bus drivers
    //////////////////////////////////////////////////
    task automatic load_data();
        foreach (data_q[k]) begin
            @(posedge clk);
            #DRIVE_DELAY;
            din_v        = 1'b1;
            din_pe       = data_q[k];
            model_mem[k] = data_q[k];               // Burst fills from address 0
        end
        @(posedge clk);
        #DRIVE_DELAY;
        din_v  = 1'b0;
        din_pe = '0;
        data_q.delete();
    endtask

    // Burst the program, let it run, then compare everything seen
    task automatic run_program(input string name);
        int waited;
        int n_inst;
        result_q.delete();
        fwd_q.delete();
        exp_q.delete();
        predict_program();
        n_inst = prog_q.size();
        foreach (prog_q[k]) begin
            @(posedge clk);
            #DRIVE_DELAY;
            inst_in_v = 1'b1;
            inst_in   = prog_q[k];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        inst_in_v = 1'b0;
        inst_in   = '0;
        waited    = 0;
        while (result_q.size() < exp_q.size()) begin
            if (waited > WAIT_LIMIT) begin
                $display("ERROR %s: results stopped arriving on dout_v", name);
                $display("FAIL: see errors above");
                $fatal(1, "result timeout");
            end
            @(posedge clk);
            waited++;
        end
        // Let the whole program drain to catch stray strobes
        while (waited < n_inst + `PE_LATENCY + 2) begin
            @(posedge clk);
            waited++;
        end
        check_value(name, "forwarded count", n_inst, fwd_q.size());
        foreach (prog_q[k]) begin
            check_value(name, $sformatf("forwarded %0d", k), prog_q[k], fwd_q[k]);
        end
        check_value(name, "result count", exp_q.size(), result_q.size());
        foreach (exp_q[k]) begin
            check_value(name, $sformatf("result %0d", k), exp_q[k], result_q[k]);
        end
        prog_q.delete();
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////
    task automatic test_forwarding();
        for (int k = 0; k < 8; k++) begin           // Scattered fields, no results
            prog_q.push_back(make_inst(pe_isa_pkg::OP_NOP, 1'(random_bits(1)),
                                       random_addr(4), random_addr(4), random_addr(4)));
        end
        run_program("forwarding");
    endtask

    task automatic test_load_move();
        for (int k = 0; k < `DMEM_DEPTH; k++) begin
            data_q.push_back(random_sample());
        end
        load_data();
        for (int k = 0; k < `IMEM_DEPTH; k++) begin
            prog_q.push_back(make_inst(pe_isa_pkg::OP_MOV, 1'b0, '0, AW'(k), random_addr(4)));
        end
        run_program("load_move");
    endtask

    task automatic test_add_sub();
        data_q.push_back(pe_data_pkg::cpx_t'({16'h7fff, 16'h8000}));    // Wrap corners
        data_q.push_back(pe_data_pkg::cpx_t'({16'h0001, 16'hffff}));
        data_q.push_back(pe_data_pkg::cpx_t'({16'h8000, 16'h7fff}));
        for (int k = 3; k < 8; k++) begin
            data_q.push_back(random_sample());
        end
        load_data();
        prog_q.push_back(make_inst(pe_isa_pkg::OP_ADD, 1'b0, '0, 4'd0, 4'd1));
        prog_q.push_back(make_inst(pe_isa_pkg::OP_SUB, 1'b0, '0, 4'd2, 4'd1));
        for (int k = 0; k < 6; k++) begin
            prog_q.push_back(make_inst(k % 2 == 0 ? pe_isa_pkg::OP_ADD : pe_isa_pkg::OP_SUB,
                                       1'b0, '0, random_addr(3), random_addr(3)));
        end
        run_program("add_sub");
    endtask

    task automatic test_mul_cmul();
        for (int k = 0; k < 8; k++) begin
            data_q.push_back(random_sample());
        end
        load_data();
        for (int k = 0; k < 10; k++) begin
            if (k % 3 == 1) begin
                prog_q.push_back(make_inst(pe_isa_pkg::OP_NOP, 1'b0, '0, '0, '0));
            end else begin
                prog_q.push_back(make_inst(k % 2 == 0 ? pe_isa_pkg::OP_MUL : pe_isa_pkg::OP_CMUL,
                                           1'b0, '0, random_addr(3), random_addr(3)));
            end
        end
        run_program("mul_cmul");
    endtask

    task automatic test_writeback();
        for (int k = 0; k < 4; k++) begin
            data_q.push_back(random_sample());
        end
        load_data();
        prog_q.push_back(make_inst(pe_isa_pkg::OP_MUL, 1'b1, 4'd5, 4'd0, 4'd1));
        repeat (3) prog_q.push_back(make_inst(pe_isa_pkg::OP_NOP, 1'b0, '0, '0, '0));
        prog_q.push_back(make_inst(pe_isa_pkg::OP_ADD, 1'b1, 4'd6, 4'd5, 4'd2));
        repeat (3) prog_q.push_back(make_inst(pe_isa_pkg::OP_NOP, 1'b0, '0, '0, '0));
        prog_q.push_back(make_inst(pe_isa_pkg::OP_MOV, 1'b0, '0, 4'd6, 4'd0));   // Final value
        run_program("writeback");
    endtask

    // Second, shorter burst must replace the first program entirely
    task automatic test_reload();
        for (int k = 0; k < 6; k++) begin
            data_q.push_back(random_sample());
        end
        load_data();
        for (int k = 0; k < 8; k++) begin
            prog_q.push_back(make_inst(pe_isa_pkg::OP_SUB, 1'b0, '0, random_addr(4),
                                       random_addr(4)));
        end
        run_program("reload_first");
        for (int k = 0; k < 3; k++) begin
            prog_q.push_back(make_inst(pe_isa_pkg::OP_CMUL, 1'b0, '0, random_addr(4),
                                       random_addr(4)));
        end
        run_program("reload_second");
    endtask

    initial begin
        lfsr_state  = 32'hbb6d;
        reset       = 1'b1;
        din_v       = 1'b0;
        din_pe      = '0;
        inst_in_v   = 1'b0;
        inst_in     = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        test_forwarding();
        test_load_move();
        test_add_sub();
        test_mul_cmul();
        test_writeback();
        test_reload();
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule
